//--- Bender.yml
package:
  name: x_tile_path

sources:
  # Packages first, then the RTL from leaf modules up to the top level
  - rtl/xbuf_cfg_pkg.sv
  - rtl/xbuf_ctrl_pkg.sv
  - rtl/x_row_loader.sv
  - rtl/x_tile_buffer.sv
  - rtl/dot_engine.sv
  - rtl/x_tile_top.sv

  - target: test
    files:
      - testbench/tb_x_tile_top.sv

//--- project.f
rtl/xbuf_cfg_pkg.sv
rtl/xbuf_ctrl_pkg.sv
rtl/x_row_loader.sv
rtl/x_tile_buffer.sv
rtl/dot_engine.sv
rtl/x_tile_top.sv
testbench/tb_x_tile_top.sv

//--- rtl/dot_engine.sv
// Row of TILE_ROWS MAC lanes. Each lane takes the dot product of one tile row
// with the weight vector, one column per cycle, and offers it under back-pressure.
`default_nettype none

module dot_engine (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] weight_i,
  input  logic                                                        weight_load_i,
  input  logic                                                        tile_ready_i,
  output logic [xbuf_cfg_pkg::COL_IDX_W-1:0]                          col_idx_o,
  input  logic [xbuf_cfg_pkg::TILE_ROWS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] col_i,
  output logic                                                        tile_release_o,
  output logic [xbuf_cfg_pkg::TILE_ROWS-1:0][xbuf_cfg_pkg::ACC_W-1:0]  result_o,
  output logic                                                        result_valid_o,
  input  logic                                                        result_ready_i
);
  import xbuf_cfg_pkg::*;
  import xbuf_ctrl_pkg::*;

  engine_state_e                    state_q, state_d;
  logic [COL_IDX_W-1:0]             col_q;
  logic [ROW_ELEMS-1:0][ELEM_W-1:0] weight_q;
  logic [TILE_ROWS-1:0][ACC_W-1:0]  acc_q, acc_d;
  logic                             last_col;

  assign last_col = col_q == COL_IDX_W'(ROW_ELEMS - 1);

  always_comb begin : fsm
    state_d = state_q;
    case (state_q)
      ENG_IDLE: if (tile_ready_i) state_d = ENG_MAC;
      ENG_MAC:  if (last_col) state_d = ENG_OUT;
      ENG_OUT:  if (result_ready_i) state_d = ENG_IDLE;
      default:  state_d = ENG_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= ENG_IDLE;
      col_q   <= '0;
    end else if (clear_i) begin
      state_q <= ENG_IDLE;
      col_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ENG_MAC) begin
        col_q <= last_col ? '0 : col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : weight_reg
    if (weight_load_i) begin
      weight_q <= weight_i;
    end
  end

  // Products are sign extended into the wide accumulators
  always_comb begin : lane_products
    logic signed [2*ELEM_W-1:0] prod;
    for (int r = 0; r < TILE_ROWS; r++) begin
      prod     = $signed(col_i[r]) * $signed(weight_q[col_q]);
      acc_d[r] = $signed(acc_q[r]) + ACC_W'(prod);
    end
  end

  always_ff @(posedge clk_i) begin : lane_accumulators
    if (state_q == ENG_IDLE && tile_ready_i) begin
      acc_q <= '0;
    end else if (state_q == ENG_MAC) begin
      acc_q <= acc_d;
    end
  end

  // The bank is handed back as soon as its last column is read, not when the
  // result is taken, so the buffer can refill behind a stalled result
  assign tile_release_o = state_q == ENG_MAC && last_col;
  assign col_idx_o      = col_q;
  assign result_o       = acc_q;
  assign result_valid_o = state_q == ENG_OUT;

  a_result_stable : assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o))
    else $error("result changed before it was accepted");

endmodule

`default_nettype wire

//--- rtl/x_row_loader.sv
// Host-side row loader. Accepts rows on a valid/ready handshake and forwards
// them, one cycle later, to the tile buffer while it holds credits.
`default_nettype none

module x_row_loader (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic                                                        row_valid_i,
  input  logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] row_i,
  input  logic                                                        row_last_i,
  output logic                                                        row_ready_o,
  input  logic                                                        credit_i,
  output logic                                                        wr_en_o,
  output logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] wr_row_o,
  output logic                                                        wr_last_o
);
  import xbuf_cfg_pkg::*;

  logic signed [CREDIT_W-1:0] credit_q, credit_d, spend;
  logic [ROW_IDX_W-1:0]       pos_q;
  logic                       accept;

  assign row_ready_o = credit_q > 0;
  assign accept      = row_valid_i && row_ready_o;

  // A last row also pays for the rows the buffer pads with zeros, since the
  // buffer returns a full bank of credits when it frees that bank
  always_comb begin : credit_next
    spend = '0;
    if (accept) begin
      if (row_last_i) begin
        spend = $signed(CREDIT_W'(TILE_ROWS - pos_q));
      end else begin
        spend = $signed(CREDIT_W'(1));
      end
    end
    credit_d = credit_q - spend + $signed({{(CREDIT_W-1){1'b0}}, credit_i});
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : credit_counter
    if (!rst_ni) begin
      credit_q <= $signed(CREDIT_W'(ROW_SLOTS));
      pos_q    <= '0;
    end else if (clear_i) begin
      credit_q <= $signed(CREDIT_W'(ROW_SLOTS));
      pos_q    <= '0;
    end else begin
      credit_q <= credit_d;
      if (accept) begin
        if (row_last_i || pos_q == ROW_IDX_W'(TILE_ROWS - 1)) begin
          pos_q <= '0;
        end else begin
          pos_q <= pos_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : write_valid
    if (!rst_ni) begin
      wr_en_o <= 1'b0;
    end else if (clear_i) begin
      wr_en_o <= 1'b0;
    end else begin
      wr_en_o <= accept;
    end
  end

  always_ff @(posedge clk_i) begin : write_payload
    if (accept) begin
      wr_row_o  <= row_i;
      wr_last_o <= row_last_i;
    end
  end

  // The buffer must never hand back more credits than were spent
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= $signed(CREDIT_W'(ROW_SLOTS)))
    else $error("loader credit count above ROW_SLOTS");

endmodule

`default_nettype wire

//--- rtl/x_tile_buffer.sv
// Double-banked X tile store. Collects TILE_ROWS rows per bank, pads short tiles
// with zeros, returns credits on release and serves the tile column by column.
`default_nettype none

module x_tile_buffer (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic                                                        wr_en_i,
  input  logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] wr_row_i,
  input  logic                                                        wr_last_i,
  output logic                                                        credit_o,
  input  logic [xbuf_cfg_pkg::COL_IDX_W-1:0]                          col_idx_i,
  output logic                                                        tile_ready_o,
  output logic [xbuf_cfg_pkg::TILE_ROWS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] col_o,
  input  logic                                                        tile_release_i
);
  import xbuf_cfg_pkg::*;
  import xbuf_ctrl_pkg::*;

  logic [ROW_ELEMS-1:0][ELEM_W-1:0] mem_q [NUM_BANKS][TILE_ROWS];
  bank_state_e                      bank_q [NUM_BANKS];
  logic [BANK_IDX_W-1:0]            wr_bank_q, rd_bank_q;
  logic [ROW_IDX_W-1:0]             row_idx_q;
  logic [CREDIT_W-1:0]              pend_q;
  logic                             tile_close;

  // A tile closes on its last slot or on the final row of the matrix
  assign tile_close = wr_en_i && (wr_last_i || row_idx_q == ROW_IDX_W'(TILE_ROWS - 1));

  // The whole remainder of a short tile is zeroed in the same cycle as its last row
  always_ff @(posedge clk_i) begin : bank_store
    if (wr_en_i) begin
      for (int r = 0; r < TILE_ROWS; r++) begin
        if (ROW_IDX_W'(r) == row_idx_q) begin
          mem_q[wr_bank_q][r] <= wr_row_i;
        end else if (wr_last_i && ROW_IDX_W'(r) > row_idx_q) begin
          mem_q[wr_bank_q][r] <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : bank_ctrl
    if (!rst_ni) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_q[b] <= BANK_EMPTY;
      end
      wr_bank_q <= '0;
      rd_bank_q <= '0;
      row_idx_q <= '0;
    end else if (clear_i) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_q[b] <= BANK_EMPTY;
      end
      wr_bank_q <= '0;
      rd_bank_q <= '0;
      row_idx_q <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (tile_release_i && BANK_IDX_W'(b) == rd_bank_q) begin
          bank_q[b] <= BANK_EMPTY;
        end else if (wr_en_i && BANK_IDX_W'(b) == wr_bank_q) begin
          bank_q[b] <= tile_close ? BANK_READY : BANK_FILLING;
        end
      end
      if (tile_release_i) begin
        rd_bank_q <= rd_bank_q + 1'b1;
      end
      if (tile_close) begin
        wr_bank_q <= wr_bank_q + 1'b1;
        row_idx_q <= '0;
      end else if (wr_en_i) begin
        row_idx_q <= row_idx_q + 1'b1;
      end
    end
  end

  // A freed bank queues a full bank of credits, drained one per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : credit_queue
    if (!rst_ni) begin
      pend_q <= '0;
    end else if (clear_i) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_q - CREDIT_W'(credit_o) + (tile_release_i ? CREDIT_W'(TILE_ROWS) : '0);
    end
  end

  assign credit_o     = pend_q != '0;
  assign tile_ready_o = bank_q[rd_bank_q] == BANK_READY;

  // Transposed read: element col_idx_i of every row in the read bank
  always_comb begin : col_select
    for (int r = 0; r < TILE_ROWS; r++) begin
      col_o[r] = mem_q[rd_bank_q][r][col_idx_i];
    end
  end

  // Credits in the loader must keep writes away from a bank the engine still owns
  a_no_write_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> bank_q[wr_bank_q] != BANK_READY)
    else $error("row written into a ready bank");

  a_release_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_release_i |-> tile_ready_o)
    else $error("tile released while read bank not ready");

endmodule

`default_nettype wire

//--- rtl/x_tile_top.sv
// Top level of the X operand path: row loader, double-banked tile buffer and
// dot engine, connected by wires only.
`default_nettype none

module x_tile_top (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  logic                                                        clear_i,
  input  logic                                                        row_valid_i,
  input  logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] row_i,
  input  logic                                                        row_last_i,
  output logic                                                        row_ready_o,
  input  logic [xbuf_cfg_pkg::ROW_ELEMS-1:0][xbuf_cfg_pkg::ELEM_W-1:0] weight_i,
  input  logic                                                        weight_load_i,
  output logic [xbuf_cfg_pkg::TILE_ROWS-1:0][xbuf_cfg_pkg::ACC_W-1:0]  result_o,
  output logic                                                        result_valid_o,
  input  logic                                                        result_ready_i
);
  import xbuf_cfg_pkg::*;

  logic                             wr_en, wr_last, credit;
  logic [ROW_ELEMS-1:0][ELEM_W-1:0] wr_row;
  logic [COL_IDX_W-1:0]             col_idx;
  logic [TILE_ROWS-1:0][ELEM_W-1:0] col;
  logic                             tile_ready, tile_release;

  x_row_loader u_loader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .row_valid_i (row_valid_i),
    .row_i       (row_i),
    .row_last_i  (row_last_i),
    .row_ready_o (row_ready_o),
    .credit_i    (credit),
    .wr_en_o     (wr_en),
    .wr_row_o    (wr_row),
    .wr_last_o   (wr_last)
  );

  x_tile_buffer u_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .wr_en_i        (wr_en),
    .wr_row_i       (wr_row),
    .wr_last_i      (wr_last),
    .credit_o       (credit),
    .col_idx_i      (col_idx),
    .tile_ready_o   (tile_ready),
    .col_o          (col),
    .tile_release_i (tile_release)
  );

  dot_engine u_engine (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .weight_i       (weight_i),
    .weight_load_i  (weight_load_i),
    .tile_ready_i   (tile_ready),
    .col_idx_o      (col_idx),
    .col_i          (col),
    .tile_release_o (tile_release),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

endmodule

`default_nettype wire

//--- rtl/xbuf_cfg_pkg.sv
// Shared sizes of the X operand path: element format, tile shape and banking.
// Modules import this package inside their bodies and use scoped names in port lists.
`default_nettype none

package xbuf_cfg_pkg;

  // Element width of the signed X and weight values
  localparam int unsigned ELEM_W    = 16;
  // Elements per host row, which is also the number of columns of a tile
  localparam int unsigned ROW_ELEMS = 4;
  // Rows per tile, which is also the number of MAC lanes
  localparam int unsigned TILE_ROWS = 4;
  localparam int unsigned NUM_BANKS = 2;
  // Row slots across both banks and the loader's starting credit count
  localparam int unsigned ROW_SLOTS = NUM_BANKS * TILE_ROWS;
  localparam int unsigned ACC_W     = 40;

  localparam int unsigned COL_IDX_W  = $clog2(ROW_ELEMS);
  localparam int unsigned ROW_IDX_W  = $clog2(TILE_ROWS);
  localparam int unsigned BANK_IDX_W = $clog2(NUM_BANKS);
  // One extra bit so the loader's counter can go negative while it owes
  // the slots that zero padding used up
  localparam int unsigned CREDIT_W   = $clog2(ROW_SLOTS + 1) + 1;

endpackage

`default_nettype wire

//--- rtl/xbuf_ctrl_pkg.sv
// State encodings of the tile buffer banks and of the dot engine FSM.
`default_nettype none

package xbuf_ctrl_pkg;

  // Life cycle of one bank: written row by row, then held until released
  typedef enum logic [1:0] {
    BANK_EMPTY,
    BANK_FILLING,
    BANK_READY
  } bank_state_e;

  // Engine waits for a tile, walks its columns, then offers the result
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_MAC,
    ENG_OUT
  } engine_state_e;

endpackage

`default_nettype wire

//--- testbench/tb_x_tile_top.sv
// Testbench for the X operand path. Streams matrices from a case table, checks every
// result lane against a dot-product model and exercises stalls, random ready and clear.
`default_nettype none

module tb_x_tile_top;
  import xbuf_cfg_pkg::*;

  localparam int NUM_CASES      = 8;
  localparam int MAX_ROWS       = 32;
  localparam int DUTY_ALWAYS    = 0;
  localparam int DUTY_RANDOM    = 1;
  localparam int DUTY_HOLD      = 2;
  localparam int DUTY_CLEAR     = 3;
  // With one result stalled the engine has freed one tile and both banks fill behind it
  localparam int HOLD_ROWS      = TILE_ROWS + ROW_SLOTS;
  localparam int STALL_CYCLES   = 40;
  localparam int ROW_TIMEOUT    = 200;
  localparam int RESULT_TIMEOUT = 300;

  // Stimulus table: tiles per matrix, rows in the last tile and the result_ready pattern
  int case_tiles [NUM_CASES] = '{2, 3, 2, 5, 4, 2, 3, 1};
  int case_last  [NUM_CASES] = '{4, 1, 3, 4, 2, 2, 4, 3};
  int case_duty  [NUM_CASES] = '{DUTY_ALWAYS, DUTY_ALWAYS, DUTY_RANDOM, DUTY_HOLD,
                                 DUTY_RANDOM, DUTY_CLEAR, DUTY_RANDOM, DUTY_ALWAYS};

  logic                             clk_i = 1'b0;
  logic                             rst_ni;
  logic                             clear_i;
  logic                             row_valid_i;
  logic [ROW_ELEMS-1:0][ELEM_W-1:0] row_i;
  logic                             row_last_i;
  logic                             row_ready_o;
  logic [ROW_ELEMS-1:0][ELEM_W-1:0] weight_i;
  logic                             weight_load_i;
  logic [TILE_ROWS-1:0][ACC_W-1:0]  result_o;
  logic                             result_valid_o;
  logic                             result_ready_i;

  logic signed [ELEM_W-1:0] x_rows [MAX_ROWS][ROW_ELEMS];
  logic signed [ELEM_W-1:0] weights [ROW_ELEMS];
  logic [31:0]              rng_state = 32'h488;
  int                       errors = 0;
  logic                     stalled;
  logic                     push_done;

  x_tile_top u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clear_i        (clear_i),
    .row_valid_i    (row_valid_i),
    .row_i          (row_i),
    .row_last_i     (row_last_i),
    .row_ready_o    (row_ready_o),
    .weight_i       (weight_i),
    .weight_load_i  (weight_load_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Lane value of one tile: signed dot product of its row with the weights, zero if padded
  function automatic logic [ACC_W-1:0] lane_expect(input int tile, input int lane,
                                                   input int n_rows);
    longint sum;
    int     row;
    sum = 0;
    row = tile * TILE_ROWS + lane;
    if (row < n_rows) begin
      for (int c = 0; c < ROW_ELEMS; c++) begin
        sum += longint'(x_rows[row][c]) * longint'(weights[c]);
      end
    end
    return ACC_W'(sum);
  endfunction

  task automatic make_matrix(input int n_rows);
    logic [31:0] rnd;
    for (int r = 0; r < n_rows; r++) begin
      for (int c = 0; c < ROW_ELEMS; c++) begin
        rnd = next_rand();
        x_rows[r][c] = rnd[ELEM_W-1:0];
      end
    end
    for (int c = 0; c < ROW_ELEMS; c++) begin
      rnd = next_rand();
      weights[c] = rnd[ELEM_W-1:0];
    end
  endtask

  task automatic load_weights();
    @(negedge clk_i);
    for (int c = 0; c < ROW_ELEMS; c++) begin
      weight_i[c] = weights[c];
    end
    weight_load_i = 1'b1;
    @(negedge clk_i);
    weight_load_i = 1'b0;
  endtask

  // row_ready_o is registered, so its value at the falling edge holds at the next rising edge
  task automatic push_rows(input int n_rows, input int duty);
    int idx;
    int low_cnt;
    idx = 0;
    low_cnt = 0;
    while (idx < n_rows) begin
      @(negedge clk_i);
      row_valid_i = 1'b1;
      for (int c = 0; c < ROW_ELEMS; c++) begin
        row_i[c] = x_rows[idx][c];
      end
      // A matrix that is cleared midway never sends its last row
      row_last_i = (idx == n_rows - 1) && (duty != DUTY_CLEAR);
      if (row_ready_o) begin
        idx++;
        low_cnt = 0;
      end else begin
        low_cnt++;
        if (duty == DUTY_HOLD && !stalled && low_cnt == STALL_CYCLES) begin
          stalled = 1'b1;
          if (idx != HOLD_ROWS) begin
            $display("[ERROR] rows accepted before row_ready_o fell: got %h expected %h",
                     idx, HOLD_ROWS);
            errors++;
          end
        end
        if (low_cnt > ROW_TIMEOUT) begin
          $display("Timeout: row_ready_o stayed low while rows were waiting");
          errors++;
          break;
        end
      end
    end
    if (duty == DUTY_HOLD && !stalled) begin
      $display("row_ready_o never stalled while the result was held back");
      errors++;
    end
    @(negedge clk_i);
    row_valid_i = 1'b0;
    row_last_i = 1'b0;
    push_done = 1'b1;
  endtask

  task automatic collect_results(input int n_tiles, input int n_rows, input int duty);
    int                              tile;
    int                              wait_cnt;
    logic                            rdy;
    logic                            held;
    logic [TILE_ROWS-1:0][ACC_W-1:0] held_val;
    logic [31:0]                     rnd;
    logic [ACC_W-1:0]                exp_val;
    tile = 0;
    wait_cnt = 0;
    held = 1'b0;
    while (tile < n_tiles) begin
      @(negedge clk_i);
      rnd = next_rand();
      case (duty)
        DUTY_RANDOM: rdy = rnd[0];
        DUTY_HOLD:   rdy = stalled || push_done;
        default:     rdy = 1'b1;
      endcase
      result_ready_i = rdy;
      if (result_valid_o) begin
        if (held && result_o !== held_val) begin
          $display("[ERROR] result_o changed while unaccepted: got %h expected %h",
                   result_o, held_val);
          errors++;
        end
        if (rdy) begin
          for (int lane = 0; lane < TILE_ROWS; lane++) begin
            exp_val = lane_expect(tile, lane, n_rows);
            if (result_o[lane] !== exp_val) begin
              $display("[ERROR] result_o tile %0d lane %0d: got %h expected %h",
                       tile, lane, result_o[lane], exp_val);
              errors++;
            end
          end
          tile++;
          wait_cnt = 0;
          held = 1'b0;
        end else begin
          held = 1'b1;
          held_val = result_o;
        end
      end
      wait_cnt++;
      if (wait_cnt > RESULT_TIMEOUT) begin
        $display("Timeout: no result for tile %0d", tile);
        errors++;
        break;
      end
    end
  endtask

  // Drops the partial matrix while a result is stalled and one bank is half written
  task automatic clear_midstream();
    int wait_cnt;
    wait_cnt = 0;
    while (!result_valid_o && wait_cnt < RESULT_TIMEOUT) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!result_valid_o) begin
      $display("Timeout: no result appeared before clear_i");
      errors++;
    end
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    if (row_ready_o !== 1'b1) begin
      $display("[ERROR] row_ready_o after clear_i: got %h expected %h", row_ready_o, 1'b1);
      errors++;
    end
    if (result_valid_o !== 1'b0) begin
      $display("[ERROR] result_valid_o after clear_i: got %h expected %h",
               result_valid_o, 1'b0);
      errors++;
    end
  endtask

  task automatic run_case(input int idx);
    int n_tiles;
    int n_rows;
    int duty;
    n_tiles = case_tiles[idx];
    n_rows = (n_tiles - 1) * TILE_ROWS + case_last[idx];
    duty = case_duty[idx];
    make_matrix(n_rows);
    load_weights();
    stalled = 1'b0;
    push_done = 1'b0;
    if (duty == DUTY_CLEAR) begin
      result_ready_i = 1'b0;
      push_rows(n_rows, duty);
      clear_midstream();
    end else begin
      fork
        push_rows(n_rows, duty);
        collect_results(n_tiles, n_rows, duty);
      join
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    clear_i = 1'b0;
    row_valid_i = 1'b0;
    row_i = '0;
    row_last_i = 1'b0;
    weight_i = '0;
    weight_load_i = 1'b0;
    result_ready_i = 1'b0;
    stalled = 1'b0;
    push_done = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (row_ready_o !== 1'b1) begin
      $display("[ERROR] row_ready_o after reset: got %h expected %h", row_ready_o, 1'b1);
      errors++;
    end
    if (result_valid_o !== 1'b0) begin
      $display("[ERROR] result_valid_o after reset: got %h expected %h",
               result_valid_o, 1'b0);
      errors++;
    end
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i);
    end
    $display("Run complete with %0d error(s)", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
